/* common/scpad_macros.svh */
`ifndef SCPAD_MACROS_SVH
`define SCPAD_MACROS_SVH

// one dram beat and one scratchpad line
`define SCPAD_BEAT_W 64
`define SCPAD_BEATS_MAX 8
`define SCPAD_BEAT_IDX_W 3
`define SCPAD_LINE_W 512

// bank depth
`define SCPAD_ROWS 16

// dram request side
`define DRAM_ADDR_W 32
`define DRAM_CREDITS 4
`define DRAM_TAG_W 3

`endif

/* common/scpad_pkg.sv */
`include "scpad_macros.svh"

package scpad_pkg;

    // data widths
    typedef logic [`SCPAD_BEAT_W-1:0] beat_data_t;
    typedef logic [`SCPAD_LINE_W-1:0] line_data_t;

    // dram beat address
    typedef logic [`DRAM_ADDR_W-1:0] dram_addr_t;

    // id layout: fill tag on top, beat index in the low bits
    typedef logic [`DRAM_TAG_W+`SCPAD_BEAT_IDX_W-1:0] dram_id_t;

    // beats per line, legal range 1..8
    typedef logic [3:0] beat_cnt_t;

    // bank row select
    typedef logic [$clog2(`SCPAD_ROWS)-1:0] row_idx_t;

    // has to hold the full credit count, not just count-1
    typedef logic [$clog2(`DRAM_CREDITS+1)-1:0] credit_cnt_t;

    // request issuer fsm
    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT_LINE
    } issuer_state_t;

endpackage

/* design/scpad_config_regs.sv */
`timescale 1ns/10ps
`include "scpad_macros.svh"

module scpad_config_regs (
    input  logic                clk,
    input  logic                n_rst,
    input  logic                cfg_wr_en,
    input  logic                cfg_sel,
    input  scpad_pkg::dram_addr_t cfg_wdata,
    output scpad_pkg::beat_cnt_t  num_request,
    output scpad_pkg::dram_addr_t dram_base
);
    import scpad_pkg::*;

    logic cnt_legal;

    // beat count must land in 1..8, anything else keeps the old value
    assign cnt_legal = (cfg_wdata != '0) && (cfg_wdata <= dram_addr_t'(`SCPAD_BEATS_MAX));

    // sel 0 -> beat count
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            num_request <= beat_cnt_t'(`SCPAD_BEATS_MAX);
        end else if (cfg_wr_en && !cfg_sel && cnt_legal) begin
            num_request <= beat_cnt_t'(cfg_wdata);
        end
    end

    // sel 1 -> dram base address
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            dram_base <= '0;
        end else if (cfg_wr_en && cfg_sel) begin
            dram_base <= cfg_wdata;
        end
    end

    // issuer and assembler both compare against this count
    property p_num_request_range;
        @(posedge clk) disable iff (!n_rst)
            (num_request >= beat_cnt_t'(1)) &&
            (num_request <= beat_cnt_t'(`SCPAD_BEATS_MAX));
    endproperty

    a_num_request_range: assert property (p_num_request_range)
        else $error("num_request out of range: %0d", num_request);

endmodule

/* dram_fill/dram_request_issuer.sv */
`timescale 1ns/10ps
`include "scpad_macros.svh"

module dram_request_issuer (
    input  logic                  clk,
    input  logic                  n_rst,
    input  logic                  cmd_valid,
    input  scpad_pkg::dram_addr_t cmd_line_addr,
    input  scpad_pkg::row_idx_t   cmd_row,
    input  scpad_pkg::beat_cnt_t  num_request,
    input  scpad_pkg::dram_addr_t dram_base,
    input  logic                  dram_credit_return,
    input  logic                  line_done,
    output logic                  cmd_ready,
    output logic                  dram_req_valid,
    output scpad_pkg::dram_addr_t dram_req_addr,
    output scpad_pkg::dram_id_t   dram_req_id,
    output scpad_pkg::row_idx_t   fill_row
);
    import scpad_pkg::*;

    issuer_state_t           state, state_nxt;
    beat_cnt_t               issued_cnt;
    credit_cnt_t             credits;
    logic [`DRAM_TAG_W-1:0]  fill_tag;
    dram_addr_t              line_base;
    logic                    cmd_accept;
    logic                    last_beat;

    assign cmd_ready  = (state == IDLE);
    assign cmd_accept = cmd_valid && cmd_ready;

    // one beat per cycle, only with a credit in hand
    assign dram_req_valid = (state == ISSUE) && (credits != '0);
    assign last_beat      = (issued_cnt == num_request - beat_cnt_t'(1));

    assign dram_req_addr = line_base + dram_addr_t'(issued_cnt);
    assign dram_req_id   = {fill_tag, issued_cnt[`SCPAD_BEAT_IDX_W-1:0]};

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:      if (cmd_accept) state_nxt = ISSUE;
            ISSUE:     if (dram_req_valid && last_beat) state_nxt = WAIT_LINE;
            WAIT_LINE: if (line_done) state_nxt = IDLE;
            default:   state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state      <= IDLE;
            issued_cnt <= '0;
            fill_tag   <= '0;
        end else begin
            state <= state_nxt;
            if (cmd_accept) begin
                issued_cnt <= '0;
                fill_tag   <= fill_tag + 1'b1;
            end else if (dram_req_valid) begin
                issued_cnt <= issued_cnt + beat_cnt_t'(1);
            end
        end
    end

    // spend on request, refill on return; both at once is a wash
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            credits <= credit_cnt_t'(`DRAM_CREDITS);
        end else begin
            case ({dram_req_valid, dram_credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // line base and destination row, held for the whole fill
    always_ff @(posedge clk) begin
        if (cmd_accept) begin
            line_base <= dram_base + (cmd_line_addr << `SCPAD_BEAT_IDX_W);
            fill_row  <= cmd_row;
        end
    end

    a_no_req_without_credit: assert property (
        @(posedge clk) disable iff (!n_rst)
            dram_req_valid |-> (credits != '0))
        else $error("request issued with zero credits");

    // a return with nothing outstanding would push us past the limit
    a_credit_ceiling: assert property (
        @(posedge clk) disable iff (!n_rst)
            credits <= credit_cnt_t'(`DRAM_CREDITS))
        else $error("credit count %0d above limit", credits);

endmodule

/* dram_fill/dram_response_assembler.sv */
`timescale 1ns/10ps
`include "scpad_macros.svh"

module dram_response_assembler (
    input  logic                   clk,
    input  logic                   n_rst,
    input  logic                   dram_res_valid,
    input  scpad_pkg::dram_id_t    dram_res_id,
    input  scpad_pkg::beat_data_t  dram_rddata,
    input  scpad_pkg::row_idx_t    fill_row,
    input  scpad_pkg::beat_cnt_t   num_request,
    input  logic                   be_stall,
    output logic                   sram_write_req_valid,
    output scpad_pkg::row_idx_t    sram_write_row,
    output scpad_pkg::line_data_t  sram_write_data,
    output logic                   line_done
);
    import scpad_pkg::*;

    line_data_t                    line_q;
    row_idx_t                      row_q;
    beat_cnt_t                     done_cnt;
    beat_cnt_t                     done_cnt_inc;
    logic                          line_pending;
    logic [`SCPAD_BEAT_IDX_W-1:0]  beat_idx;
    logic                          line_write;

    // low id bits say which 64-bit slice this beat fills
    assign beat_idx     = dram_res_id[`SCPAD_BEAT_IDX_W-1:0];
    assign done_cnt_inc = done_cnt + beat_cnt_t'(1);

    // full line goes out on the first unstalled cycle
    assign line_write = line_pending && !be_stall;

    assign sram_write_req_valid = line_write;
    assign sram_write_row       = row_q;
    assign sram_write_data      = line_q;
    assign line_done            = line_write;

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            done_cnt     <= '0;
            line_pending <= 1'b0;
        end else if (line_write) begin
            done_cnt     <= '0;
            line_pending <= 1'b0;
        end else if (dram_res_valid) begin
            done_cnt <= done_cnt_inc;
            if (done_cnt_inc == num_request) begin
                line_pending <= 1'b1;
            end
        end
    end

    // line starts from zero so unused slices read back as 0
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            line_q <= '0;
        end else if (line_write) begin
            line_q <= '0;
        end else if (dram_res_valid) begin
            line_q[beat_idx*`SCPAD_BEAT_W +: `SCPAD_BEAT_W] <= dram_rddata;
        end
    end

    always_ff @(posedge clk) begin
        if (dram_res_valid) begin
            row_q <= fill_row;
        end
    end

    // issuer holds off the next line until line_done, so nothing
    // should land on top of a finished line
    a_no_res_while_pending: assert property (
        @(posedge clk) disable iff (!n_rst)
            line_pending |-> !dram_res_valid)
        else $error("response id %h while line pending", dram_res_id);

    // beats only come for slices the current count covers
    a_beat_in_range: assert property (
        @(posedge clk) disable iff (!n_rst)
            dram_res_valid |-> (beat_cnt_t'(beat_idx) < num_request))
        else $error("beat index %0d beyond count %0d", beat_idx, num_request);

endmodule

/* design/scpad_line_bank.sv */
`timescale 1ns/10ps
`include "scpad_macros.svh"

module scpad_line_bank (
    input  logic                  clk,
    input  logic                  n_rst,
    input  logic                  wr_en,
    input  scpad_pkg::row_idx_t   wr_row,
    input  scpad_pkg::line_data_t wr_data,
    input  logic                  rd_en,
    input  scpad_pkg::row_idx_t   rd_row,
    output scpad_pkg::line_data_t rd_data
);
    import scpad_pkg::*;

    line_data_t              mem [`SCPAD_ROWS];
    logic [`SCPAD_ROWS-1:0]  row_vld;

    // storage array
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_row] <= wr_data;
        end
    end

    // rows never written read back as zero
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            row_vld <= '0;
        end else if (wr_en) begin
            row_vld[wr_row] <= 1'b1;
        end
    end

    // registered read with data one cycle after rd_en
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            rd_data <= '0;
        end else if (rd_en) begin
            if (row_vld[rd_row]) begin
                rd_data <= mem[rd_row];
            end else begin
                rd_data <= '0;
            end
        end
    end

endmodule

/* design/scpad_fill_top.sv */
`timescale 1ns/10ps

module scpad_fill_top (
    input  logic                  clk,
    input  logic                  n_rst,
    // config
    input  logic                  cfg_wr_en,
    input  logic                  cfg_sel,
    input  scpad_pkg::dram_addr_t cfg_wdata,
    // fill command
    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    input  scpad_pkg::dram_addr_t cmd_line_addr,
    input  scpad_pkg::row_idx_t   cmd_row,
    // dram requests
    output logic                  dram_req_valid,
    output scpad_pkg::dram_addr_t dram_req_addr,
    output scpad_pkg::dram_id_t   dram_req_id,
    input  logic                  dram_credit_return,
    // dram responses
    input  logic                  dram_res_valid,
    input  scpad_pkg::dram_id_t   dram_res_id,
    input  scpad_pkg::beat_data_t dram_rddata,
    // back end
    input  logic                  be_stall,
    input  logic                  rd_en,
    input  scpad_pkg::row_idx_t   rd_row,
    output scpad_pkg::line_data_t rd_data,
    output logic                  fill_done
);
    import scpad_pkg::*;

    beat_cnt_t  num_request;
    dram_addr_t dram_base;
    row_idx_t   fill_row;
    logic       sram_write_req_valid;
    row_idx_t   sram_write_row;
    line_data_t sram_write_data;

    scpad_config_regs u_config (
        .clk         (clk),
        .n_rst       (n_rst),
        .cfg_wr_en   (cfg_wr_en),
        .cfg_sel     (cfg_sel),
        .cfg_wdata   (cfg_wdata),
        .num_request (num_request),
        .dram_base   (dram_base)
    );

    // fill_done doubles as the issuer's line_done
    dram_request_issuer u_issuer (
        .clk                (clk),
        .n_rst              (n_rst),
        .cmd_valid          (cmd_valid),
        .cmd_line_addr      (cmd_line_addr),
        .cmd_row            (cmd_row),
        .num_request        (num_request),
        .dram_base          (dram_base),
        .dram_credit_return (dram_credit_return),
        .line_done          (fill_done),
        .cmd_ready          (cmd_ready),
        .dram_req_valid     (dram_req_valid),
        .dram_req_addr      (dram_req_addr),
        .dram_req_id        (dram_req_id),
        .fill_row           (fill_row)
    );

    dram_response_assembler u_assembler (
        .clk                  (clk),
        .n_rst                (n_rst),
        .dram_res_valid       (dram_res_valid),
        .dram_res_id          (dram_res_id),
        .dram_rddata          (dram_rddata),
        .fill_row             (fill_row),
        .num_request          (num_request),
        .be_stall             (be_stall),
        .sram_write_req_valid (sram_write_req_valid),
        .sram_write_row       (sram_write_row),
        .sram_write_data      (sram_write_data),
        .line_done            (fill_done)
    );

    scpad_line_bank u_bank (
        .clk     (clk),
        .n_rst   (n_rst),
        .wr_en   (sram_write_req_valid),
        .wr_row  (sram_write_row),
        .wr_data (sram_write_data),
        .rd_en   (rd_en),
        .rd_row  (rd_row),
        .rd_data (rd_data)
    );

endmodule

/* testbench/tb_scpad_fill.sv */
`timescale 1ns/10ps
`include "scpad_macros.svh"

module tb_scpad_fill;
    import scpad_pkg::*;

    localparam int NUM_VEC        = 24;
    localparam int VEC_COLS       = 5;
    localparam int CYCLES_PER_VEC = 200;

    logic       clk;
    logic       n_rst;
    logic       cfg_wr_en;
    logic       cfg_sel;
    dram_addr_t cfg_wdata;
    logic       cmd_valid;
    logic       cmd_ready;
    dram_addr_t cmd_line_addr;
    row_idx_t   cmd_row;
    logic       dram_req_valid;
    dram_addr_t dram_req_addr;
    dram_id_t   dram_req_id;
    logic       dram_credit_return;
    logic       dram_res_valid;
    dram_id_t   dram_res_id;
    beat_data_t dram_rddata;
    logic       be_stall;
    logic       rd_en;
    row_idx_t   rd_row;
    line_data_t rd_data;
    logic       fill_done;

    // count, line, row, reverse, stall per vector
    logic [31:0] vec_mem [NUM_VEC*VEC_COLS];

    // dram model state
    dram_addr_t addr_q [$];
    dram_id_t   id_q [$];
    integer     seed = 51885;
    int         gap = 0;
    int         issued_cnt = 0;
    int         resp_cnt = 0;
    int         outstanding;

    // expectations for the fill in flight
    int         exp_count = 8;
    dram_addr_t exp_base = '0;
    dram_addr_t exp_line = '0;
    int         fill_issued = 0;
    int         fill_resp = 0;
    logic       rev_mode = 1'b0;
    logic [`DRAM_TAG_W-1:0] fill_tag = '0;
    logic       fill_tag_known = 1'b0;

    scpad_fill_top u_scpad_fill_top (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input line_data_t got,
                                   input line_data_t exp);
        $display("Error: %s = %0h, expected %0h", name, got, exp);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1);
    endtask

    // beat data is the address on top and its inverse below
    function automatic beat_data_t beat_word(input dram_addr_t addr);
        return {addr, ~addr};
    endfunction

    function automatic line_data_t expected_line(input dram_addr_t base,
                                                 input dram_addr_t line, input int count);
        line_data_t exp;
        exp = '0;
        for (int i = 0; i < count; i++) begin
            exp[i*`SCPAD_BEAT_W +: `SCPAD_BEAT_W] = beat_word(base + line * 8 + i);
        end
        return exp;
    endfunction

    task automatic cfg_write(input logic sel, input dram_addr_t data);
        @(posedge clk);
        #2;
        cfg_wr_en = 1'b1;
        cfg_sel   = sel;
        cfg_wdata = data;
        @(posedge clk);
        #2;
        cfg_wr_en = 1'b0;
    endtask

    task automatic read_row(input row_idx_t row, output line_data_t data);
        @(posedge clk);
        #2;
        rd_en  = 1'b1;
        rd_row = row;
        @(posedge clk);
        #2;
        rd_en = 1'b0;
        @(negedge clk);
        data = rd_data;
    endtask

    task automatic run_fill(input int idx);
        int         cnt;
        int         stall;
        int         waited;
        dram_addr_t line;
        dram_addr_t base;
        row_idx_t   row;
        line_data_t got;
        cnt   = vec_mem[idx*VEC_COLS];
        line  = vec_mem[idx*VEC_COLS+1];
        row   = row_idx_t'(vec_mem[idx*VEC_COLS+2]);
        stall = vec_mem[idx*VEC_COLS+4];
        base  = 32'h1000_0000 + idx * 32'h0002_0000;
        // an illegal count leaves the old one in place
        if (cnt >= 1 && cnt <= `SCPAD_BEATS_MAX) begin
            exp_count = cnt;
        end
        cfg_write(1'b0, dram_addr_t'(cnt));
        cfg_write(1'b1, base);
        @(negedge clk);
        while (!cmd_ready) @(negedge clk);
        @(posedge clk);
        #2;
        exp_base      = base;
        exp_line      = line;
        fill_issued   = 0;
        fill_resp     = 0;
        rev_mode      = vec_mem[idx*VEC_COLS+3][0];
        be_stall      = (stall != 0);
        cmd_valid     = 1'b1;
        cmd_line_addr = line;
        cmd_row       = row;
        @(posedge clk);
        #2;
        cmd_valid = 1'b0;
        waited = 0;
        @(negedge clk);
        while (fill_resp < exp_count && waited < CYCLES_PER_VEC) begin
            @(negedge clk);
            waited++;
        end
        assert (fill_issued == exp_count)
            else report_mismatch("dram_req_valid count", fill_issued, exp_count);
        if (stall != 0) begin
            repeat (stall) @(posedge clk);
            #2;
            be_stall = 1'b0;
        end
        @(negedge clk);
        while (!fill_done) @(negedge clk);
        read_row(row, got);
        assert (got == expected_line(base, line, exp_count))
            else report_mismatch("rd_data", got, expected_line(base, line, exp_count));
    endtask

    // request monitor and credit bookkeeping sampled mid-cycle
    always @(negedge clk) begin
        if (dram_req_valid) begin
            assert (fill_issued < exp_count)
                else report_failure("DRAM request issued beyond the configured beat count");
            assert (dram_req_addr == exp_base + exp_line * 8 + fill_issued)
                else report_mismatch("dram_req_addr", dram_req_addr,
                                     dram_addr_t'(exp_base + exp_line * 8 + fill_issued));
            assert (dram_req_id[2:0] == fill_issued[2:0])
                else report_mismatch("dram_req_id", dram_req_id[2:0], fill_issued[2:0]);
            // each command advances the fill tag by one
            if (fill_issued == 0) begin
                fill_tag       = fill_tag_known ? fill_tag + 1'b1 : dram_req_id[`DRAM_TAG_W+2:3];
                fill_tag_known = 1'b1;
            end
            assert (dram_req_id[`DRAM_TAG_W+2:3] == fill_tag)
                else report_mismatch("dram_req_id tag", dram_req_id[`DRAM_TAG_W+2:3], fill_tag);
            addr_q.push_back(dram_req_addr);
            id_q.push_back(dram_req_id);
            fill_issued++;
            issued_cnt++;
        end
        // a response driven this cycle returns its credit at the next edge
        outstanding = issued_cnt - (resp_cnt - int'(dram_res_valid));
        assert (outstanding <= `DRAM_CREDITS)
            else report_failure("more DRAM requests outstanding than credits allow");
        assert (!(fill_done && be_stall))
            else report_mismatch("fill_done", fill_done, 1'b0);
    end

    // dram model with random gaps and LIFO order when reversing
    initial begin
        dram_res_valid     = 1'b0;
        dram_credit_return = 1'b0;
        dram_res_id        = '0;
        dram_rddata        = '0;
        forever begin
            @(posedge clk);
            #2;
            dram_res_valid     = 1'b0;
            dram_credit_return = 1'b0;
            if (addr_q.size() > 0) begin
                if (gap > 0) begin
                    gap--;
                end else if (!rev_mode || addr_q.size() >= `DRAM_CREDITS ||
                             fill_issued >= exp_count) begin
                    if (rev_mode) begin
                        dram_rddata = beat_word(addr_q.pop_back());
                        dram_res_id = id_q.pop_back();
                    end else begin
                        dram_rddata = beat_word(addr_q.pop_front());
                        dram_res_id = id_q.pop_front();
                    end
                    dram_res_valid     = 1'b1;
                    dram_credit_return = 1'b1;
                    resp_cnt++;
                    fill_resp++;
                    gap = {$random(seed)} % 4;
                end
            end
        end
    end

    initial begin
        repeat (NUM_VEC * CYCLES_PER_VEC + 100) @(posedge clk);
        $display("Timeout: the fill sequence did not finish in time");
        $display("** FAIL **");
        $fatal(1);
    end

    initial begin
        line_data_t got;
        n_rst         = 1'b0;
        cfg_wr_en     = 1'b0;
        cfg_sel       = 1'b0;
        cfg_wdata     = '0;
        cmd_valid     = 1'b0;
        cmd_line_addr = '0;
        cmd_row       = '0;
        be_stall      = 1'b0;
        rd_en         = 1'b0;
        rd_row        = '0;
        $readmemh("testbench/scpad_fill_vectors.txt", vec_mem);
        assert (!$isunknown(vec_mem[NUM_VEC*VEC_COLS-1]))
            else report_failure("vector file missing or shorter than expected");
        repeat (3) @(posedge clk);
        #2;
        n_rst = 1'b1;
        @(negedge clk);
        assert (cmd_ready == 1'b1) else report_mismatch("cmd_ready", cmd_ready, 1'b1);
        assert (dram_req_valid == 1'b0)
            else report_mismatch("dram_req_valid", dram_req_valid, 1'b0);
        assert (fill_done == 1'b0) else report_mismatch("fill_done", fill_done, 1'b0);
        // empty bank reads back zero
        for (int r = 0; r < `SCPAD_ROWS; r++) begin
            read_row(row_idx_t'(r), got);
            assert (got == '0) else report_mismatch("rd_data", got, '0);
        end
        for (int i = 0; i < NUM_VEC; i++) begin
            run_fill(i);
        end
        repeat (4) @(posedge clk);
        $display("** PASS **");
        $finish;
    end

endmodule

/* testbench/scpad_fill_vectors.txt */
// one fill per line, all hex
// count  line_addr  row  reverse  stall_cycles
// a count of 0 or 9 is an illegal write, the previous count stays
8 10 0 0 0
4 2a 1 0 0
1 3 2 0 0
8 7 3 1 0
5 100 4 1 3
0 11 5 0 0
2 40 6 0 5
9 41 7 1 2
7 abc 8 1 0
3 55 9 0 a
6 66 a 1 1
8 1234 b 1 4
0 77 c 1 0
1 88 d 1 6
2 99 e 0 0
8 aa f 0 8
3 bb 0 1 0
4 cc 1 0 2
9 dd 2 0 0
5 ee 3 1 0
6 ff 4 0 1
7 fff 5 1 3
8 ffff 6 1 0
1 12345 7 0 2

/* tb.f */
+incdir+common
common/scpad_pkg.sv
design/scpad_config_regs.sv
dram_fill/dram_request_issuer.sv
dram_fill/dram_response_assembler.sv
design/scpad_line_bank.sv
design/scpad_fill_top.sv
testbench/tb_scpad_fill.sv
